//--- bench/inv_ctrl_assert.sv
// Checker bound into the top level; assumes MMU requests stay high while the TLB command is up
`timescale 1ns/100ps
`default_nettype none

module inv_ctrl_assert (
  input logic inv_sm_clk,
  input logic cpurst_b,
  input logic rst_inv_req,
  input logic fence_mmu_req,
  input logic op_done,
  input logic clk_en,
  input logic icache_inv_req,
  input logic bht_inv,
  input logic lsu_icc_req,
  input logic tlb_all_inv,
  input logic tlb_asid_all_inv,
  input logic tlb_va_all_inv,
  input logic tlb_va_asid_inv
);

  logic [3:0] tlb_kind;
  logic       quiet;
  logic       mmu_src;

  assign tlb_kind = {tlb_all_inv, tlb_asid_all_inv, tlb_va_all_inv, tlb_va_asid_inv};
  // No command on any unit
  assign quiet = !icache_inv_req && !bht_inv && !lsu_icc_req && (tlb_kind == 4'b0000);
  assign mmu_src = rst_inv_req || fence_mmu_req;

  // --------------------
  // Properties
  // --------------------
  // Units leave done one edge after op_done, so the clock must be off one cycle later
  a_clk_off: assert property (@(posedge inv_sm_clk) disable iff (!cpurst_b)
    (op_done && $past(op_done) && quiet) |-> !clk_en)
    else $error("clk_en high with no pending work");

  a_tlb_gated: assert property (@(posedge inv_sm_clk) disable iff (!cpurst_b)
    (tlb_kind != 4'b0000) |-> (mmu_src && $past(mmu_src)))
    else $error("TLB invalidate raised without MMU request");

  a_tlb_single: assert property (@(posedge inv_sm_clk) disable iff (!cpurst_b)
    $onehot0(tlb_kind))
    else $error("Several TLB invalidate kinds raised together");

endmodule

bind inv_ctrl_top inv_ctrl_assert u_assert (
  .inv_sm_clk       (inv_sm_clk),
  .cpurst_b         (cpurst_b),
  .rst_inv_req      (rst_inv_req),
  .fence_mmu_req    (fence_mmu_req),
  .op_done          (op_done),
  .clk_en           (clk_en),
  .icache_inv_req   (icache_inv_req),
  .bht_inv          (bht_inv),
  .lsu_icc_req      (lsu_icc_req),
  .tlb_all_inv      (tlb_all_inv),
  .tlb_asid_all_inv (tlb_asid_all_inv),
  .tlb_va_all_inv   (tlb_va_all_inv),
  .tlb_va_asid_inv  (tlb_va_asid_inv)
);

`default_nettype wire

//--- bench/tb_clkgen.sv
// Free-running testbench clock, 100 ns period starting low; never stops on its own
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic inv_sm_clk
);

  // Half period of 50 ns
  initial
  begin
    inv_sm_clk = 1'b0;
    forever #50 inv_sm_clk = ~inv_sm_clk;
  end

endmodule

`default_nettype wire

//--- bench/tb_inv_ctrl.sv
// Drives on falling edges and checks on rising edges; unit models answer within 0 to 7 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_inv_ctrl;

  import inv_pkg::*;

  localparam int num_ops    = 26;
  localparam int max_cycles = num_ops * 16 + 20;

  logic inv_sm_clk, cpurst_b;
  logic rst_inv_req, fence_icache_req, fence_dcache_req, fence_mmu_req;
  logic icacheop_req, dcacheop_req;
  logic [1:0] cacheop_type, cacheop_op;
  logic sfence_va_all, sfence_asid_all, sfence_va_asid;
  logic [63:0] rs1, rs2, icache_inv_addr, lsu_icc_addr;
  logic [1:0] icache_inv_type, lsu_icc_type, lsu_icc_op;
  logic icache_inv_req, bht_inv, lsu_icc_req, op_done, clk_en;
  logic tlb_all_inv, tlb_asid_all_inv, tlb_va_all_inv, tlb_va_asid_inv;
  logic [26:0] tlb_va;
  logic [15:0] tlb_asid;
  logic [3:0] tlb_kind, cmd_vec, done_vec, armed;
  int delay [4];
  integer seed = 3987;
  int cycles = 0;
  int error_count = 0;
  // Expected values, set with each request
  logic [3:0] exp_units, exp_kind, started, finished, cmd_exp;
  logic [1:0] exp_itype, exp_dtype, exp_dop;
  logic [63:0] exp_iaddr, exp_daddr;
  logic [26:0] exp_va;
  logic [15:0] exp_asid;
  logic done_exp, clk_en_exp;
  logic [63:0] a, b;
  logic [4:0] mix;

  tb_clkgen u_clkgen (.inv_sm_clk(inv_sm_clk));

  inv_ctrl_top u_dut (
    .inv_sm_clk(inv_sm_clk), .cpurst_b(cpurst_b), .rst_inv_req(rst_inv_req),
    .fence_icache_req(fence_icache_req), .fence_dcache_req(fence_dcache_req),
    .fence_mmu_req(fence_mmu_req), .icacheop_req(icacheop_req), .dcacheop_req(dcacheop_req),
    .cacheop_type(cacheop_type), .cacheop_op(cacheop_op), .sfence_va_all(sfence_va_all),
    .sfence_asid_all(sfence_asid_all), .sfence_va_asid(sfence_va_asid), .rs1(rs1), .rs2(rs2),
    .icache_inv_done(done_vec[0]), .bht_inv_done(done_vec[1]),
    .dcache_icc_done(done_vec[2]), .tlb_inv_done(done_vec[3]),
    .icache_inv_req(icache_inv_req), .icache_inv_type(icache_inv_type),
    .icache_inv_addr(icache_inv_addr), .bht_inv(bht_inv), .lsu_icc_req(lsu_icc_req),
    .lsu_icc_type(lsu_icc_type), .lsu_icc_op(lsu_icc_op), .lsu_icc_addr(lsu_icc_addr),
    .tlb_all_inv(tlb_all_inv), .tlb_asid_all_inv(tlb_asid_all_inv),
    .tlb_va_all_inv(tlb_va_all_inv), .tlb_va_asid_inv(tlb_va_asid_inv),
    .tlb_va(tlb_va), .tlb_asid(tlb_asid), .op_done(op_done), .clk_en(clk_en)
  );

  // Unit order is icache, bht, dcache, mmu
  assign tlb_kind = {tlb_all_inv, tlb_asid_all_inv, tlb_va_all_inv, tlb_va_asid_inv};
  assign cmd_vec  = {|tlb_kind, lsu_icc_req, bht_inv, icache_inv_req};

  // Reference; reqs is {dcacheop, icacheop, fence_mmu, fence_dcache, fence_icache, reset}
  function automatic void compute_expected(input logic [5:0] reqs, input logic [1:0] ctype,
    input logic [1:0] cop, input logic [2:0] sflags, input logic [63:0] op_a,
    input logic [63:0] op_b);
    exp_units = {reqs[0] | reqs[3], reqs[0] | reqs[2] | reqs[5], reqs[0],
                 reqs[0] | reqs[1] | reqs[4]};
    exp_itype = reqs[4] ? ctype : cache_type_all;
    exp_dtype = reqs[5] ? ctype : cache_type_all;
    exp_dop   = reqs[5] ? cop : (reqs[2] ? dcache_op_clr : dcache_op_inv);
    exp_iaddr = op_a & ~64'h1;
    exp_daddr = op_a;
    // Kind is {all, asid_all, va_all, va_asid}
    if ($countones(sflags) == 1)
      exp_kind = {1'b0, sflags[1], sflags[2], sflags[0]};
    else
      exp_kind = 4'b1000;
    exp_va   = op_a[38:12];
    exp_asid = op_b[15:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
    input logic [63:0] act_val);
    if (act_val !== exp_val)
    begin
      error_count++;
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Hold the request until op_done, then drop it on the falling edge
  task automatic run_op(input logic [5:0] reqs, input logic [1:0] ctype, input logic [1:0] cop,
    input logic [2:0] sflags, input logic [63:0] op_a, input logic [63:0] op_b);
    @(negedge inv_sm_clk);
    {dcacheop_req, icacheop_req, fence_mmu_req} = reqs[5:3];
    {fence_dcache_req, fence_icache_req, rst_inv_req} = reqs[2:0];
    cacheop_type = ctype;
    cacheop_op = cop;
    {sfence_va_all, sfence_asid_all, sfence_va_asid} = sflags;
    rs1 = op_a;
    rs2 = op_b;
    compute_expected(reqs, ctype, cop, sflags, op_a, op_b);
    @(posedge inv_sm_clk);
    while (op_done !== 1'b1)
      @(posedge inv_sm_clk);
    @(negedge inv_sm_clk);
    {dcacheop_req, icacheop_req, fence_mmu_req} = 3'b000;
    {fence_dcache_req, fence_icache_req, rst_inv_req} = 3'b000;
    exp_units = 4'b0000;
  endtask

  // --------------------
  // Unit response models
  // --------------------
  always @(negedge inv_sm_clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (done_vec[i])
      begin
        done_vec[i] = 1'b0;
        armed[i] = 1'b0;
      end
      else if (cmd_vec[i])
      begin
        if (!armed[i])
        begin
          armed[i] = 1'b1;
          delay[i] = $unsigned($random(seed)) % 8;
        end
        if (delay[i] == 0)
          done_vec[i] = 1'b1;
        else
          delay[i] = delay[i] - 1;
      end
    end
  end

  // --------------------
  // Compare against the model
  // --------------------
  always @(posedge inv_sm_clk)
  begin
    if (cpurst_b)
    begin
      cmd_exp    = started & ~finished;
      done_exp   = &(finished | ~exp_units);
      clk_en_exp = (|exp_units) || (|started);
      check_value("op_done", 64'(done_exp), 64'(op_done));
      check_value("clk_en", 64'(clk_en_exp), 64'(clk_en));
      check_value("commands", 64'(cmd_exp), 64'(cmd_vec));
      check_value("tlb_kind", 64'(cmd_exp[3] ? exp_kind : 4'b0000), 64'(tlb_kind));
      if (cmd_exp[0])
      begin
        check_value("icache_inv_type", 64'(exp_itype), 64'(icache_inv_type));
        check_value("icache_inv_addr", exp_iaddr, icache_inv_addr);
      end
      if (cmd_exp[2])
      begin
        check_value("lsu_icc_type", 64'(exp_dtype), 64'(lsu_icc_type));
        check_value("lsu_icc_op", 64'(exp_dop), 64'(lsu_icc_op));
        check_value("lsu_icc_addr", exp_daddr, lsu_icc_addr);
      end
      if (cmd_exp[3])
      begin
        check_value("tlb_va", 64'(exp_va), 64'(tlb_va));
        check_value("tlb_asid", 64'(exp_asid), 64'(tlb_asid));
      end
      finished = finished | done_vec;
      if (op_done)
      begin
        started  = 4'b0000;
        finished = 4'b0000;
      end
      else
        started = started | exp_units;
    end
  end

  always @(posedge inv_sm_clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Timeout after %0d cycles, op_done never completed the test list", cycles);
      $display("TEST FAILED");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial
  begin
    {rst_inv_req, fence_icache_req, fence_dcache_req, fence_mmu_req} = 4'b0000;
    {icacheop_req, dcacheop_req, sfence_va_all, sfence_asid_all, sfence_va_asid} = 5'b00000;
    cacheop_type = 2'b00;
    cacheop_op = 2'b00;
    rs1 = 64'h0;
    rs2 = 64'h0;
    done_vec = 4'b0000;
    armed = 4'b0000;
    {exp_units, started, finished} = 12'h000;
    cpurst_b = 1'b0;
    repeat (8) @(posedge inv_sm_clk);
    @(negedge inv_sm_clk);
    cpurst_b = 1'b1;
    // Quiet after reset
    repeat (5) @(negedge inv_sm_clk);
    // Type and op inputs set away from the defaults the commands must carry
    run_op(6'b000001, 2'b11, 2'b11, 3'b000, {$random(seed), $random(seed)}, 64'h0);
    run_op(6'b000010, 2'b11, 2'b11, 3'b000, 64'h0, 64'h0);
    run_op(6'b000100, 2'b11, 2'b11, 3'b000, 64'h0, 64'h0);
    run_op(6'b001000, 2'b11, 2'b11, 3'b000, 64'h0, 64'h0);
    for (int k = 0; k < 4; k++)
      run_op(6'b010000, 2'($random(seed)), 2'($random(seed)), 3'b000,
             {$random(seed), $random(seed)}, 64'h0);
    for (int k = 0; k < 4; k++)
      run_op(6'b100000, 2'($random(seed)), 2'($random(seed)), 3'b000,
             {$random(seed), $random(seed)}, 64'h0);
    for (int f = 0; f < 8; f++)
      run_op(6'b001000, 2'b00, 2'b00, 3'(f), {$random(seed), $random(seed)},
             {$random(seed), $random(seed)});
    // Several units at once
    for (int k = 0; k < 6; k++)
    begin
      mix = 5'($random(seed));
      if (mix == 5'b00000)
        mix = 5'b00100;
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      run_op({mix, 1'b0}, 2'($random(seed)), 2'($random(seed)), 3'($random(seed)), a, b);
    end
    repeat (3) @(negedge inv_sm_clk);
    if (error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only when the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_inv_ctrl -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" <<< "$out"; then
  exit 0
fi
exit 1

//--- sim.f
source/inv_pkg.sv
source/inv_unit_fsm.sv
source/inv_rst_seq.sv
source/inv_join.sv
source/inv_cmd_format.sv
source/inv_ctrl_top.sv
bench/tb_clkgen.sv
bench/inv_ctrl_assert.sv
bench/tb_inv_ctrl.sv

//--- source/inv_cmd_format.sv
// Command fields are only meaningful while the matching wfc flag is high; rs2 above ASID is ignored
`timescale 1ns/100ps
`default_nettype none

module inv_cmd_format (
  input  logic                               icache_wfc,
  input  logic                               bht_wfc,
  input  logic                               dcache_wfc,
  input  logic                               mmu_wfc,
  input  logic                               icacheop_req,
  input  logic                               dcacheop_req,
  input  logic                               fence_dcache_req,
  input  logic [inv_pkg::cacheop_w-1:0]      cacheop_type,
  input  logic [inv_pkg::cacheop_w-1:0]      cacheop_op,
  input  logic                               sfence_va_all,
  input  logic                               sfence_asid_all,
  input  logic                               sfence_va_asid,
  input  inv_pkg::rs1_word_u                 rs1,
  input  logic [inv_pkg::xlen-1:0]           rs2,
  output logic                               icache_inv_req,
  output logic [inv_pkg::cacheop_w-1:0]      icache_inv_type,
  output logic [inv_pkg::xlen-1:0]           icache_inv_addr,
  output logic                               bht_inv,
  output logic                               lsu_icc_req,
  output logic [inv_pkg::cacheop_w-1:0]      lsu_icc_type,
  output logic [inv_pkg::cacheop_w-1:0]      lsu_icc_op,
  output logic [inv_pkg::xlen-1:0]           lsu_icc_addr,
  output logic                               tlb_all_inv,
  output logic                               tlb_asid_all_inv,
  output logic                               tlb_va_all_inv,
  output logic                               tlb_va_asid_inv,
  output logic [inv_pkg::vpn_w-1:0]          tlb_va,
  output logic [inv_pkg::asid_w-1:0]         tlb_asid
);

  import inv_pkg::*;

  logic [3:0] tlb_kind;

  // --------------------
  // Icache and BHT
  // --------------------
  assign icache_inv_req  = icache_wfc;
  assign icache_inv_type = icacheop_req ? cacheop_type : cache_type_all;
  // Fetch addresses are halfword aligned
  assign icache_inv_addr = {rs1.addr[xlen-1:1], 1'b0};

  assign bht_inv = bht_wfc;

  // --------------------
  // Dcache
  // --------------------
  assign lsu_icc_req  = dcache_wfc;
  assign lsu_icc_type = dcacheop_req ? cacheop_type : cache_type_all;
  assign lsu_icc_addr = rs1.addr;

  // Special op first, then fence clean, reset invalidates
  always_comb
  begin
    if (dcacheop_req)
      lsu_icc_op = cacheop_op;
    else if (fence_dcache_req)
      lsu_icc_op = dcache_op_clr;
    else
      lsu_icc_op = dcache_op_inv;
  end

  // --------------------
  // TLB
  // --------------------
  // tlb_kind is {all, asid_all, va_all, va_asid}
  always_comb
  begin
    case ({sfence_va_all, sfence_asid_all, sfence_va_asid})
      3'b100:  tlb_kind = 4'b0010;
      3'b010:  tlb_kind = 4'b0100;
      3'b001:  tlb_kind = 4'b0001;
      // No flag or several flags means flush everything
      default: tlb_kind = 4'b1000;
    endcase
  end

  assign tlb_all_inv      = mmu_wfc && tlb_kind[3];
  assign tlb_asid_all_inv = mmu_wfc && tlb_kind[2];
  assign tlb_va_all_inv   = mmu_wfc && tlb_kind[1];
  assign tlb_va_asid_inv  = mmu_wfc && tlb_kind[0];

  assign tlb_va   = rs1.page.vpn;
  assign tlb_asid = rs2[asid_w-1:0];

endmodule

`default_nettype wire

//--- source/inv_ctrl_top.sv
// Invalidation sequencer top; unit done pulses are one cycle and requests are held until op_done
`timescale 1ns/100ps
`default_nettype none

module inv_ctrl_top (
  input  logic                          inv_sm_clk,
  input  logic                          cpurst_b,
  input  logic                          rst_inv_req,
  input  logic                          fence_icache_req,
  input  logic                          fence_dcache_req,
  input  logic                          fence_mmu_req,
  input  logic                          icacheop_req,
  input  logic                          dcacheop_req,
  input  logic [inv_pkg::cacheop_w-1:0] cacheop_type,
  input  logic [inv_pkg::cacheop_w-1:0] cacheop_op,
  input  logic                          sfence_va_all,
  input  logic                          sfence_asid_all,
  input  logic                          sfence_va_asid,
  input  logic [inv_pkg::xlen-1:0]      rs1,
  input  logic [inv_pkg::xlen-1:0]      rs2,
  input  logic                          icache_inv_done,
  input  logic                          bht_inv_done,
  input  logic                          dcache_icc_done,
  input  logic                          tlb_inv_done,
  output logic                          icache_inv_req,
  output logic [inv_pkg::cacheop_w-1:0] icache_inv_type,
  output logic [inv_pkg::xlen-1:0]      icache_inv_addr,
  output logic                          bht_inv,
  output logic                          lsu_icc_req,
  output logic [inv_pkg::cacheop_w-1:0] lsu_icc_type,
  output logic [inv_pkg::cacheop_w-1:0] lsu_icc_op,
  output logic [inv_pkg::xlen-1:0]      lsu_icc_addr,
  output logic                          tlb_all_inv,
  output logic                          tlb_asid_all_inv,
  output logic                          tlb_va_all_inv,
  output logic                          tlb_va_asid_inv,
  output logic [inv_pkg::vpn_w-1:0]     tlb_va,
  output logic [inv_pkg::asid_w-1:0]    tlb_asid,
  output logic                          op_done,
  output logic                          clk_en
);

  logic icache_req, bht_req, dcache_req, mmu_req;
  logic icache_idle, bht_idle, dcache_idle, mmu_idle, rst_idle;
  logic icache_wfc, bht_wfc, dcache_wfc, mmu_wfc;

  // --------------------
  // Sequencers
  // --------------------
  inv_rst_seq u_rst_seq (
    .inv_sm_clk  (inv_sm_clk),
    .cpurst_b    (cpurst_b),
    .rst_inv_req (rst_inv_req),
    .op_done     (op_done),
    .rst_sm_idle (rst_idle)
  );

  inv_unit_fsm u_icache_sm (
    .inv_sm_clk (inv_sm_clk),
    .cpurst_b   (cpurst_b),
    .op_req     (icache_req),
    .unit_done  (icache_inv_done),
    .op_done    (op_done),
    .sm_idle    (icache_idle),
    .sm_wfc     (icache_wfc)
  );

  inv_unit_fsm u_bht_sm (
    .inv_sm_clk (inv_sm_clk),
    .cpurst_b   (cpurst_b),
    .op_req     (bht_req),
    .unit_done  (bht_inv_done),
    .op_done    (op_done),
    .sm_idle    (bht_idle),
    .sm_wfc     (bht_wfc)
  );

  inv_unit_fsm u_dcache_sm (
    .inv_sm_clk (inv_sm_clk),
    .cpurst_b   (cpurst_b),
    .op_req     (dcache_req),
    .unit_done  (dcache_icc_done),
    .op_done    (op_done),
    .sm_idle    (dcache_idle),
    .sm_wfc     (dcache_wfc)
  );

  inv_unit_fsm u_mmu_sm (
    .inv_sm_clk (inv_sm_clk),
    .cpurst_b   (cpurst_b),
    .op_req     (mmu_req),
    .unit_done  (tlb_inv_done),
    .op_done    (op_done),
    .sm_idle    (mmu_idle),
    .sm_wfc     (mmu_wfc)
  );

  // --------------------
  // Join and commands
  // --------------------
  inv_join u_join (
    .rst_inv_req      (rst_inv_req),
    .fence_icache_req (fence_icache_req),
    .fence_dcache_req (fence_dcache_req),
    .fence_mmu_req    (fence_mmu_req),
    .icacheop_req     (icacheop_req),
    .dcacheop_req     (dcacheop_req),
    .icache_idle      (icache_idle),
    .bht_idle         (bht_idle),
    .dcache_idle      (dcache_idle),
    .mmu_idle         (mmu_idle),
    .rst_idle         (rst_idle),
    .icache_wfc       (icache_wfc),
    .bht_wfc          (bht_wfc),
    .dcache_wfc       (dcache_wfc),
    .mmu_wfc          (mmu_wfc),
    .icache_req       (icache_req),
    .bht_req          (bht_req),
    .dcache_req       (dcache_req),
    .mmu_req          (mmu_req),
    .op_done          (op_done),
    .clk_en           (clk_en)
  );

  inv_cmd_format u_cmd_format (
    .icache_wfc       (icache_wfc),
    .bht_wfc          (bht_wfc),
    .dcache_wfc       (dcache_wfc),
    .mmu_wfc          (mmu_wfc),
    .icacheop_req     (icacheop_req),
    .dcacheop_req     (dcacheop_req),
    .fence_dcache_req (fence_dcache_req),
    .cacheop_type     (cacheop_type),
    .cacheop_op       (cacheop_op),
    .sfence_va_all    (sfence_va_all),
    .sfence_asid_all  (sfence_asid_all),
    .sfence_va_asid   (sfence_va_asid),
    .rs1              (rs1),
    .rs2              (rs2),
    .icache_inv_req   (icache_inv_req),
    .icache_inv_type  (icache_inv_type),
    .icache_inv_addr  (icache_inv_addr),
    .bht_inv          (bht_inv),
    .lsu_icc_req      (lsu_icc_req),
    .lsu_icc_type     (lsu_icc_type),
    .lsu_icc_op       (lsu_icc_op),
    .lsu_icc_addr     (lsu_icc_addr),
    .tlb_all_inv      (tlb_all_inv),
    .tlb_asid_all_inv (tlb_asid_all_inv),
    .tlb_va_all_inv   (tlb_va_all_inv),
    .tlb_va_asid_inv  (tlb_va_asid_inv),
    .tlb_va           (tlb_va),
    .tlb_asid         (tlb_asid)
  );

endmodule

`default_nettype wire

//--- source/inv_join.sv
// Request fan-out and completion join; all requests are levels held until op_done is high
`timescale 1ns/100ps
`default_nettype none

module inv_join (
  input  logic rst_inv_req,
  input  logic fence_icache_req,
  input  logic fence_dcache_req,
  input  logic fence_mmu_req,
  input  logic icacheop_req,
  input  logic dcacheop_req,
  input  logic icache_idle,
  input  logic bht_idle,
  input  logic dcache_idle,
  input  logic mmu_idle,
  input  logic rst_idle,
  input  logic icache_wfc,
  input  logic bht_wfc,
  input  logic dcache_wfc,
  input  logic mmu_wfc,
  output logic icache_req,
  output logic bht_req,
  output logic dcache_req,
  output logic mmu_req,
  output logic op_done,
  output logic clk_en
);

  logic icache_fin;
  logic bht_fin;
  logic dcache_fin;
  logic mmu_fin;

  // --------------------
  // Unit requests
  // --------------------
  assign icache_req = rst_inv_req
                   || fence_icache_req
                   || icacheop_req;
  // BHT only cleared at reset
  assign bht_req    = rst_inv_req;
  assign dcache_req = rst_inv_req
                   || fence_dcache_req
                   || dcacheop_req;
  assign mmu_req    = rst_inv_req
                   || fence_mmu_req;

  // --------------------
  // Completion join
  // --------------------
  // Finished when in done (neither idle nor wfc) or idle and not involved
  assign icache_fin = (icache_idle && !icache_req)
                   || (!icache_idle && !icache_wfc);
  assign bht_fin    = (bht_idle && !bht_req)
                   || (!bht_idle && !bht_wfc);
  assign dcache_fin = (dcache_idle && !dcache_req)
                   || (!dcache_idle && !dcache_wfc);
  assign mmu_fin    = (mmu_idle && !mmu_req)
                   || (!mmu_idle && !mmu_wfc);

  assign op_done = icache_fin
                && bht_fin
                && dcache_fin
                && mmu_fin;

  // --------------------
  // Clock enable
  // --------------------
  // Any pending work or any sequencer away from idle
  assign clk_en = !op_done
               || !icache_idle
               || !bht_idle
               || !dcache_idle
               || !mmu_idle
               || !rst_idle;

endmodule

`default_nettype wire

//--- source/inv_pkg.sv
// Shared encodings; operand layout assumes 64-bit XLEN and Sv39 pages with 4 KB offsets
`default_nettype none

package inv_pkg;

  // --------------------
  // Sequencer states
  // --------------------
  localparam logic [1:0] inv_idle = 2'b00;
  localparam logic [1:0] inv_wfc  = 2'b01;
  localparam logic [1:0] inv_done = 2'b10;

  // --------------------
  // Widths
  // --------------------
  localparam int xlen       = 64;
  localparam int vpn_w      = 27;
  localparam int asid_w     = 16;
  localparam int cacheop_w  = 2;
  localparam int page_off_w = 12;
  // Bits above the Sv39 VPN
  localparam int page_hi_w  = xlen - vpn_w - page_off_w;

  // Cache type, whole cache
  localparam logic [cacheop_w-1:0] cache_type_all = 2'b00;

  // Dcache op codes, one-hot on {clean, invalidate}
  localparam logic [cacheop_w-1:0] dcache_op_clr = 2'b10;
  localparam logic [cacheop_w-1:0] dcache_op_inv = 2'b01;

  // rs1 seen as a flat address or as a virtual page number
  typedef union packed {
    logic [xlen-1:0] addr;
    struct packed {
      logic [page_hi_w-1:0]  hi;
      logic [vpn_w-1:0]      vpn;
      logic [page_off_w-1:0] offset;
    } page;
  } rs1_word_u;

endpackage

`default_nettype wire

//--- source/inv_rst_seq.sv
// Reset invalidation tracker; rst_inv_req must stay high until op_done is seen high
`timescale 1ns/100ps
`default_nettype none

module inv_rst_seq (
  input  logic inv_sm_clk,
  input  logic cpurst_b,
  input  logic rst_inv_req,
  input  logic op_done,
  output logic rst_sm_idle
);

  import inv_pkg::*;

  logic [1:0] rst_state;
  logic [1:0] rst_state_nxt;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge inv_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rst_state <= inv_idle;
    else
      rst_state <= rst_state_nxt;
  end

  // No done state here, the join itself closes the flow
  always_comb
  begin
    case (rst_state)
      inv_idle:
      begin
        if (rst_inv_req)
          rst_state_nxt = inv_wfc;
        else
          rst_state_nxt = inv_idle;
      end
      inv_wfc:
      begin
        if (op_done)
          rst_state_nxt = inv_idle;
        else
          rst_state_nxt = inv_wfc;
      end
      default:
      begin
        rst_state_nxt = inv_idle;
      end
    endcase
  end

  // Keeps the clock alive for the whole reset flow
  assign rst_sm_idle = (rst_state == inv_idle);

endmodule

`default_nettype wire

//--- source/inv_unit_fsm.sv
// One unit's sequencer; unit_done must be a single-cycle pulse seen only while sm_wfc is high
`timescale 1ns/100ps
`default_nettype none

module inv_unit_fsm (
  input  logic inv_sm_clk,
  input  logic cpurst_b,
  input  logic op_req,
  input  logic unit_done,
  input  logic op_done,
  output logic sm_idle,
  output logic sm_wfc
);

  import inv_pkg::*;

  logic [1:0] cur_state;
  logic [1:0] next_state;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge inv_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= inv_idle;
    else
      cur_state <= next_state;
  end

  // Next state
  always_comb
  begin
    case (cur_state)
      inv_idle:
      begin
        if (op_req)
          next_state = inv_wfc;
        else
          next_state = inv_idle;
      end
      inv_wfc:
      begin
        // Command held until the unit reports back
        if (unit_done)
          next_state = inv_done;
        else
          next_state = inv_wfc;
      end
      inv_done:
      begin
        // Park here until every other unit has finished too
        if (op_done)
          next_state = inv_idle;
        else
          next_state = inv_done;
      end
      default:
      begin
        next_state = inv_idle;
      end
    endcase
  end

  assign sm_idle = (cur_state == inv_idle);
  assign sm_wfc  = (cur_state == inv_wfc);

endmodule

`default_nettype wire
